//--- execute_unit.f
hw/exec_pkg.sv
hw/alu.sv
hw/bcu.sv
hw/agu.sv
hw/multiplier.sv
hw/divider.sv
hw/execute_stage.sv
hw/execute_unit.sv
test/tb_clock.sv
test/execute_unit_checker.sv
test/execute_unit_tb.sv

//--- hw/agu.sv
`timescale 1ns/100ps

module agu import exec_pkg::*; (
  input word_t rdata1,
  input word_t imm,
  input addr_t pc,
  input logic auipc, jal, jalr, branch, load, store,
  input lsu_op_t lsu_op,
  output addr_t address,
  output byte_en_t byteenable,
  output logic exception,
  output cause_t ecause,
  output word_t etval
);

  addr_t sum;
  logic misaligned;

  // auipc, jal and branch are pc relative; the rest use rs1.
  assign sum = ((jalr | load | store) ? rdata1 : pc) + imm;
  assign address = jalr ? {sum[31:1], 1'b0} : sum;
  assign etval = address;

  always_comb begin
    byteenable = '0;
    misaligned = 1'b0;
    if (load | store) begin
      case (lsu_op)
        lb, lbu, sb: begin
          byteenable = byte_en_t'(4'b0001 << address[1:0]);
        end
        lh, lhu, sh: begin
          byteenable = byte_en_t'(4'b0011 << address[1:0]);
          misaligned = address[0];
        end
        default: begin
          byteenable = 4'b1111; // word access.
          misaligned = |address[1:0];
        end
      endcase
    end
  end

  always_comb begin
    exception = 1'b0;
    ecause = cause_instr_misaligned;
    if ((load | store) & misaligned) begin
      exception = 1'b1;
      ecause = load ? cause_load_misaligned : cause_store_misaligned;
    end else if ((jal | jalr | branch) & address[1] & !auipc) begin
      exception = 1'b1; // target not on a word boundary.
    end
  end

endmodule

//--- hw/alu.sv
`timescale 1ns/100ps

module alu import exec_pkg::*; (
  input word_t rdata1,
  input word_t rdata2,
  input word_t imm,
  input logic sel,
  input alu_op_t alu_op,
  output word_t result
);

  word_t op2;
  logic [4:0] shamt;

  assign op2 = sel ? rdata2 : imm; // register or immediate.
  assign shamt = op2[4:0];

  always_comb begin
    case (alu_op)
      add: begin
        result = rdata1 + op2;
      end
      sub: begin
        result = rdata1 - op2;
      end
      sll: begin
        result = rdata1 << shamt;
      end
      slt: begin
        result = word_t'($signed(rdata1) < $signed(op2));
      end
      sltu: begin
        result = word_t'(rdata1 < op2);
      end
      xor_op: begin
        result = rdata1 ^ op2;
      end
      srl: begin
        result = rdata1 >> shamt;
      end
      sra: begin
        result = word_t'($signed(rdata1) >>> shamt); // keeps the sign bit.
      end
      or_op: begin
        result = rdata1 | op2;
      end
      and_op: begin
        result = rdata1 & op2;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

//--- hw/bcu.sv
`timescale 1ns/100ps

module bcu import exec_pkg::*; (
  input word_t rdata1,
  input word_t rdata2,
  input bcu_op_t bcu_op,
  output logic taken
);

  logic equal;
  logic less_signed;
  logic less_unsigned;

  assign equal = (rdata1 == rdata2);
  assign less_signed = ($signed(rdata1) < $signed(rdata2));
  assign less_unsigned = (rdata1 < rdata2);

  always_comb begin
    case (bcu_op)
      beq: taken = equal;
      bne: taken = !equal;
      blt: taken = less_signed;
      bge: taken = !less_signed;
      bltu: taken = less_unsigned;
      bgeu: taken = !less_unsigned;
      default: taken = 1'b0;
    endcase
  end

endmodule

//--- hw/divider.sv
`timescale 1ns/100ps

module divider import exec_pkg::*; (
  input logic clk,
  input logic rst,
  input logic clear,
  input logic start,
  input word_t rdata1,
  input word_t rdata2,
  input div_op_t div_op,
  output logic ready,
  output word_t result
);

  div_state_t state;
  logic [4:0] count;
  word_t quotient;
  word_t remainder;
  word_t divisor;
  logic neg_q;
  logic neg_r;
  logic want_rem;

  logic signed_op;
  word_t mag_a;
  word_t mag_b;
  logic [xlen+1:0] diff;

  assign signed_op = (div_op == div) | (div_op == rem);
  assign mag_a = (signed_op & rdata1[xlen-1]) ? -rdata1 : rdata1;
  assign mag_b = (signed_op & rdata2[xlen-1]) ? -rdata2 : rdata2;

  // trial subtract of the shifted partial remainder.
  assign diff = {1'b0, remainder, quotient[xlen-1]} - {2'b00, divisor};

  always_ff @(posedge clk) begin
    if (rst == 0 || clear) begin
      state <= idle;
    end else begin
      case (state)
        busy: begin
          if (count == 5'(div_steps - 1)) begin
            state <= done;
          end
        end
        default: begin
          if (start) begin
            state <= busy;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start && state != busy) begin
      quotient <= mag_a;
      remainder <= '0;
      divisor <= mag_b;
      count <= '0;
      // a zero divisor already yields all ones, so no sign flip.
      neg_q <= signed_op & (rdata1[xlen-1] ^ rdata2[xlen-1]) & (rdata2 != '0);
      neg_r <= signed_op & rdata1[xlen-1];
      want_rem <= (div_op == rem) | (div_op == remu);
    end else if (state == busy) begin
      count <= count + 5'd1;
      if (diff[xlen+1]) begin
        remainder <= {remainder[xlen-2:0], quotient[xlen-1]}; // restore.
        quotient <= {quotient[xlen-2:0], 1'b0};
      end else begin
        remainder <= diff[xlen-1:0];
        quotient <= {quotient[xlen-2:0], 1'b1};
      end
    end
  end

  assign ready = (state == done);

  always_comb begin
    if (want_rem) begin
      result = neg_r ? -remainder : remainder;
    end else begin
      result = neg_q ? -quotient : quotient;
    end
  end

endmodule

//--- hw/exec_pkg.sv
package exec_pkg;

  // ============================================================
  // widths
  // ============================================================
  localparam int xlen = 32;
  localparam int div_steps = 32; // one quotient bit per step.

  typedef logic [xlen-1:0] word_t;
  typedef logic [xlen-1:0] addr_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [3:0] byte_en_t;
  typedef logic [3:0] cause_t;

  localparam cause_t cause_instr_misaligned = 4'd0;
  localparam cause_t cause_load_misaligned = 4'd4;
  localparam cause_t cause_store_misaligned = 4'd6;

  // ============================================================
  // operation encodings
  // ============================================================
  typedef enum logic [3:0] {
    add,
    sub,
    sll,
    slt,
    sltu,
    xor_op,
    srl,
    sra,
    or_op,
    and_op
  } alu_op_t;

  typedef enum logic [2:0] {
    beq,
    bne,
    blt,
    bge,
    bltu,
    bgeu
  } bcu_op_t;

  typedef enum logic [2:0] {
    lb,
    lbu,
    lh,
    lhu,
    lw,
    sb,
    sh,
    sw
  } lsu_op_t;

  typedef enum logic [1:0] {
    mul,
    mulh,
    mulhsu,
    mulhu
  } mul_op_t;

  typedef enum logic [1:0] {
    div,
    divu,
    rem,
    remu
  } div_op_t;

  typedef enum logic [1:0] {
    idle,
    busy,
    done
  } div_state_t;

endpackage

//--- hw/execute_stage.sv
`timescale 1ns/100ps

module execute_stage import exec_pkg::*; (
  input logic clk,
  input logic rst,
  input logic clear,
  input logic mem_stall,
  // decode side
  input logic valid,
  input addr_t pc, npc,
  input word_t imm, rdata1, rdata2,
  input logic rden2,
  input reg_addr_t waddr,
  input logic wren,
  input alu_op_t alu_op,
  input bcu_op_t bcu_op,
  input lsu_op_t lsu_op,
  input mul_op_t mul_op,
  input div_op_t div_op,
  input logic auipc, lui, jal, jalr, branch, load, store,
  input logic multiplication, division,
  // function unit operands
  output word_t op_rdata1, op_rdata2, op_imm,
  output logic op_sel,
  output alu_op_t op_alu_op,
  output bcu_op_t op_bcu_op,
  output mul_op_t op_mul_op,
  output div_op_t op_div_op,
  // function unit results
  input word_t alu_result, mul_result, div_result,
  input logic taken, div_ready, agu_exception,
  input addr_t agu_address,
  input byte_en_t agu_byteenable,
  input cause_t agu_ecause,
  input word_t agu_etval,
  output logic div_start,
  output logic stall,
  // memory stage
  output logic q_valid, q_wren, q_load, q_store, q_jump, q_exception,
  output reg_addr_t q_waddr,
  output word_t q_wdata,
  output addr_t q_address,
  output byte_en_t q_byteenable,
  output word_t q_sdata,
  output lsu_op_t q_lsu_op,
  output cause_t q_ecause,
  output word_t q_etval
);

  logic div_active;
  logic kill;
  word_t wdata;
  logic n_valid, n_wren, n_load, n_store, n_jump, n_exception;

  assign op_rdata1 = rdata1;
  assign op_rdata2 = rdata2;
  assign op_imm = imm;
  assign op_sel = rden2;
  assign op_alu_op = alu_op;
  assign op_bcu_op = bcu_op;
  assign op_mul_op = mul_op;
  assign op_div_op = div_op;

  // ============================================================
  // divide handshake
  // ============================================================
  assign div_start = valid & division & !clear & !div_active;
  assign stall = valid & division & !clear & !(div_active & div_ready);

  always_ff @(posedge clk) begin
    if (rst == 0 || clear) begin
      div_active <= 1'b0;
    end else if (div_start) begin
      div_active <= 1'b1;
    end else if (div_ready && !mem_stall) begin
      div_active <= 1'b0; // result leaves this edge.
    end
  end

  // ============================================================
  // writeback select and exception suppression
  // ============================================================
  always_comb begin
    if (auipc) begin
      wdata = agu_address;
    end else if (lui) begin
      wdata = imm;
    end else if (jal | jalr) begin
      wdata = npc;
    end else if (multiplication) begin
      wdata = mul_result;
    end else if (division) begin
      wdata = div_result;
    end else begin
      wdata = alu_result;
    end
  end

  assign kill = stall | clear | !valid;

  always_comb begin
    n_valid = valid;
    n_wren = wren & (waddr != '0); // x0 is never written.
    n_load = load;
    n_store = store;
    n_jump = jal | jalr | (branch & taken);
    n_exception = agu_exception;
    if (n_exception) begin
      if (load) begin
        n_load = 1'b0;
        n_wren = 1'b0;
      end else if (store) begin
        n_store = 1'b0;
      end else if (n_jump) begin
        n_jump = 1'b0;
        n_wren = 1'b0;
      end else begin
        n_exception = 1'b0;
      end
    end
    if (kill) begin
      n_valid = 1'b0;
      n_wren = 1'b0;
      n_load = 1'b0;
      n_store = 1'b0;
      n_jump = 1'b0;
      n_exception = 1'b0;
    end
  end

  // ============================================================
  // pipeline register
  // ============================================================
  always_ff @(posedge clk) begin
    if (rst == 0) begin
      q_valid <= 1'b0;
      q_wren <= 1'b0;
      q_load <= 1'b0;
      q_store <= 1'b0;
      q_jump <= 1'b0;
      q_exception <= 1'b0;
    end else if (clear || !mem_stall) begin
      q_valid <= n_valid;
      q_wren <= n_wren;
      q_load <= n_load;
      q_store <= n_store;
      q_jump <= n_jump;
      q_exception <= n_exception;
    end
  end

  always_ff @(posedge clk) begin
    if (!mem_stall) begin
      q_waddr <= waddr;
      q_wdata <= wdata;
      q_address <= agu_address;
      q_byteenable <= agu_byteenable;
      q_sdata <= rdata2;
      q_lsu_op <= lsu_op;
      q_ecause <= agu_ecause;
      q_etval <= agu_etval;
    end
  end

endmodule

//--- hw/execute_unit.sv
`timescale 1ns/100ps

module execute_unit import exec_pkg::*; (
  input logic clk,
  input logic rst,
  input logic clear,
  input logic mem_stall,
  input logic valid,
  input addr_t pc, npc,
  input word_t imm, rdata1, rdata2,
  input logic rden2,
  input reg_addr_t waddr,
  input logic wren,
  input alu_op_t alu_op,
  input bcu_op_t bcu_op,
  input lsu_op_t lsu_op,
  input mul_op_t mul_op,
  input div_op_t div_op,
  input logic auipc, lui, jal, jalr, branch, load, store,
  input logic multiplication, division,
  output logic stall,
  output logic q_valid, q_wren, q_load, q_store, q_jump, q_exception,
  output reg_addr_t q_waddr,
  output word_t q_wdata,
  output addr_t q_address,
  output byte_en_t q_byteenable,
  output word_t q_sdata,
  output lsu_op_t q_lsu_op,
  output cause_t q_ecause,
  output word_t q_etval
);

  word_t op_rdata1, op_rdata2, op_imm;
  logic op_sel;
  alu_op_t op_alu_op;
  bcu_op_t op_bcu_op;
  mul_op_t op_mul_op;
  div_op_t op_div_op;

  word_t alu_result, mul_result, div_result;
  logic taken, div_ready, div_start;
  logic agu_exception;
  addr_t agu_address;
  byte_en_t agu_byteenable;
  cause_t agu_ecause;
  word_t agu_etval;

  execute_stage u_stage (.*);

  alu u_alu (
    .rdata1(op_rdata1), .rdata2(op_rdata2), .imm(op_imm),
    .sel(op_sel), .alu_op(op_alu_op), .result(alu_result)
  );

  bcu u_bcu (
    .rdata1(op_rdata1), .rdata2(op_rdata2), .bcu_op(op_bcu_op), .taken(taken)
  );

  agu u_agu (
    .rdata1(op_rdata1), .imm(op_imm), .pc(pc),
    .auipc(auipc), .jal(jal), .jalr(jalr), .branch(branch),
    .load(load), .store(store), .lsu_op(lsu_op),
    .address(agu_address), .byteenable(agu_byteenable),
    .exception(agu_exception), .ecause(agu_ecause), .etval(agu_etval)
  );

  multiplier u_mul (
    .rdata1(op_rdata1), .rdata2(op_rdata2), .mul_op(op_mul_op), .result(mul_result)
  );

  divider u_div (
    .clk(clk), .rst(rst), .clear(clear), .start(div_start),
    .rdata1(op_rdata1), .rdata2(op_rdata2), .div_op(op_div_op),
    .ready(div_ready), .result(div_result)
  );

endmodule

//--- hw/multiplier.sv
`timescale 1ns/100ps

module multiplier import exec_pkg::*; (
  input word_t rdata1,
  input word_t rdata2,
  input mul_op_t mul_op,
  output word_t result
);

  logic signed_a;
  logic signed_b;
  logic signed [xlen:0] op1;
  logic signed [xlen:0] op2;
  logic signed [2*xlen+1:0] product;

  // mulhsu treats only rs1 as signed.
  assign signed_a = (mul_op == mulh) | (mul_op == mulhsu);
  assign signed_b = (mul_op == mulh);

  assign op1 = {signed_a & rdata1[xlen-1], rdata1};
  assign op2 = {signed_b & rdata2[xlen-1], rdata2};

  assign product = op1 * op2;

  assign result = (mul_op == mul) ? product[xlen-1:0] : product[2*xlen-1:xlen];

endmodule

//--- test/execute_unit_checker.sv
`timescale 1ns/100ps

module execute_unit_checker import exec_pkg::*; (
  input logic clk,
  input logic rst,
  input logic clear,
  input logic stall,
  input logic q_valid,
  input logic q_wren,
  input logic q_load,
  input logic q_store,
  input logic q_jump,
  input logic q_exception,
  input byte_en_t q_byteenable
);

  logic q_any;

  assign q_any = q_valid | q_wren | q_load | q_store | q_jump | q_exception;

  reset_clears_q: assert property (@(posedge clk) !rst |=> !q_any)
    else $error("a q control output is high after reset");

  no_faulting_load: assert property (@(posedge clk) disable iff (!rst)
    !(q_exception && q_load))
    else $error("q_load and q_exception are both high");

  clear_drops_stall: assert property (@(posedge clk) disable iff (!rst)
    clear |=> !stall)
    else $error("stall is still high one cycle after clear");

  access_has_lanes: assert property (@(posedge clk) disable iff (!rst)
    (q_load || q_store) |-> (q_byteenable != '0))
    else $error("memory access with an empty byte enable");

endmodule

bind execute_unit execute_unit_checker u_checker (.*);

//--- test/execute_unit_tb.sv
`timescale 1ns/100ps

module execute_unit_tb import exec_pkg::*; ();

  logic clk;
  logic rst;
  logic clear;
  logic mem_stall;
  logic valid;
  addr_t pc;
  addr_t npc;
  word_t imm;
  word_t rdata1;
  word_t rdata2;
  logic rden2;
  reg_addr_t waddr;
  logic wren;
  alu_op_t alu_op;
  bcu_op_t bcu_op;
  lsu_op_t lsu_op;
  mul_op_t mul_op;
  div_op_t div_op;
  logic auipc, lui, jal, jalr, branch, load, store;
  logic multiplication, division;
  logic stall;
  logic q_valid, q_wren, q_load, q_store, q_jump, q_exception;
  reg_addr_t q_waddr;
  word_t q_wdata;
  addr_t q_address;
  byte_en_t q_byteenable;
  word_t q_sdata;
  lsu_op_t q_lsu_op;
  cause_t q_ecause;
  word_t q_etval;

  logic [149:0] q_all;
  int stall_cycles;
  int cycles = 0;

  assign q_all = {q_valid, q_wren, q_load, q_store, q_jump, q_exception, q_waddr, q_wdata,
                  q_address, q_byteenable, q_sdata, q_lsu_op, q_ecause, q_etval};

  tb_clock u_clock (.clk(clk));

  execute_unit u_dut (.*);

  // about 1300 cycles of tests, limit leaves margin.
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= 3000) begin
      $display("run timed out after %0d cycles", cycles);
      $display("TEST RESULT: FAIL");
      $fatal(1, "timeout");
    end
  end

  // ============================================================
  // helpers and reference model
  // ============================================================
  task automatic expect_equal(input logic [159:0] got, input logic [159:0] want,
                              input string what);
    if (got !== want) begin
      $display("FAIL at %0t ns: %s, got %0h, expected %0h", $time, what, got, want);
      $display("TEST RESULT: FAIL");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic set_idle();
    clear = 1'b0;
    mem_stall = 1'b0;
    valid = 1'b0;
    pc = '0;
    npc = '0;
    imm = '0;
    rdata1 = '0;
    rdata2 = '0;
    rden2 = 1'b0;
    waddr = '0;
    wren = 1'b0;
    alu_op = add;
    bcu_op = beq;
    lsu_op = lb;
    mul_op = mul;
    div_op = div;
    auipc = 1'b0;
    lui = 1'b0;
    jal = 1'b0;
    jalr = 1'b0;
    branch = 1'b0;
    load = 1'b0;
    store = 1'b0;
    multiplication = 1'b0;
    division = 1'b0;
  endtask

  // called at a falling edge, returns at the falling edge after the result registers.
  task automatic wait_for_result(input int max_cycles);
    stall_cycles = 0;
    #1;
    while (stall) begin
      @(negedge clk);
      #1;
      stall_cycles++;
      if (stall_cycles >= max_cycles) begin
        $display("stall stayed high for more than %0d cycles", max_cycles);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stall timeout");
      end
    end
    @(negedge clk);
  endtask

  function automatic word_t alu_model(alu_op_t op, word_t a, word_t b);
    case (op)
      add: return a + b;
      sub: return a - b;
      sll: return a << b[4:0];
      slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      sltu: return (a < b) ? 32'd1 : 32'd0;
      xor_op: return a ^ b;
      srl: return a >> b[4:0];
      sra: return $signed(a) >>> b[4:0];
      or_op: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_model(bcu_op_t op, word_t a, word_t b);
    case (op)
      beq: return a == b;
      bne: return a != b;
      blt: return $signed(a) < $signed(b);
      bge: return $signed(a) >= $signed(b);
      bltu: return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic word_t mul_model(mul_op_t op, word_t a, word_t b);
    logic [63:0] wide_a;
    logic [63:0] wide_b;
    logic [63:0] product;
    wide_a = (op == mulh || op == mulhsu) ? {{32{a[31]}}, a} : {32'b0, a};
    wide_b = (op == mulh) ? {{32{b[31]}}, b} : {32'b0, b};
    product = wide_a * wide_b; // low 64 bits are exact.
    return (op == mul) ? product[31:0] : product[63:32];
  endfunction

  function automatic word_t div_model(div_op_t op, word_t a, word_t b);
    int sa;
    int sb;
    sa = a;
    sb = b;
    if (b == '0) begin
      return (op == div || op == divu) ? '1 : a;
    end
    if (a == 32'h8000_0000 && b == '1 && (op == div || op == rem)) begin
      return (op == div) ? a : '0; // signed overflow.
    end
    case (op)
      div: return sa / sb;
      divu: return a / b;
      rem: return sa % sb;
      default: return a % b;
    endcase
  endfunction

  // ============================================================
  // directed tests
  // ============================================================
  task automatic test_alu();
    word_t a;
    word_t b;
    word_t c;
    logic use_reg;
    reg_addr_t rd;
    for (int i = 0; i < 200; i++) begin
      a = $urandom;
      b = $urandom;
      c = $urandom;
      use_reg = $urandom_range(0, 1);
      rd = (i % 7 == 0) ? 5'd0 : reg_addr_t'($urandom_range(1, 31));
      set_idle();
      valid = 1'b1;
      rdata1 = a;
      rdata2 = b;
      imm = c;
      rden2 = use_reg;
      alu_op = alu_op_t'(i % 10);
      wren = 1'b1;
      waddr = rd;
      wait_for_result(1);
      expect_equal(q_wdata, alu_model(alu_op_t'(i % 10), a, use_reg ? b : c), "alu result");
      expect_equal(q_wren, rd != 5'd0, "alu wren");
      expect_equal(q_valid, 1'b1, "alu valid");
    end
  endtask

  task automatic check_jump(input logic is_jalr, input addr_t at, input word_t base,
                            input word_t offset);
    addr_t target;
    logic bad;
    target = is_jalr ? ((base + offset) & 32'hffff_fffe) : (at + offset);
    bad = target[1];
    set_idle();
    valid = 1'b1;
    jal = !is_jalr;
    jalr = is_jalr;
    pc = at;
    npc = at + 32'd4;
    rdata1 = base;
    imm = offset;
    wren = 1'b1;
    waddr = 5'd1;
    wait_for_result(1);
    expect_equal(q_address, target, "jump target");
    expect_equal(q_jump, !bad, "jump taken");
    expect_equal(q_wren, !bad, "link wren");
    expect_equal(q_exception, bad, "jump exception");
    if (bad) begin
      expect_equal(q_ecause, cause_instr_misaligned, "jump cause");
      expect_equal(q_etval, target, "jump tval");
    end else begin
      expect_equal(q_wdata, at + 32'd4, "link value");
    end
  endtask

  task automatic test_jumps();
    set_idle();
    valid = 1'b1;
    lui = 1'b1;
    imm = 32'habcd_e000;
    wren = 1'b1;
    waddr = 5'd2;
    wait_for_result(1);
    expect_equal(q_wdata, 32'habcd_e000, "lui value");
    set_idle();
    valid = 1'b1;
    auipc = 1'b1;
    pc = 32'h1000_0040;
    imm = 32'h0001_2000;
    wren = 1'b1;
    waddr = 5'd2;
    wait_for_result(1);
    expect_equal(q_wdata, 32'h1001_2040, "auipc value");
    check_jump(1'b0, 32'h0000_2000, 32'h0, 32'h0000_0120);
    check_jump(1'b0, 32'h0000_2000, 32'h0, 32'h0000_0102); // bit 1 set.
    check_jump(1'b1, 32'h0000_3000, 32'h0000_4000, 32'h0000_0011); // bit 0 dropped.
    check_jump(1'b1, 32'h0000_3000, 32'h0000_4000, 32'h0000_0006);
  endtask

  task automatic test_branches();
    word_t lhs[5] = '{32'd7, 32'd1, 32'd2, 32'hffff_fffd, 32'd4};
    word_t rhs[5] = '{32'd7, 32'd2, 32'd1, 32'd4, 32'hffff_fffd};
    for (int k = 0; k < 6; k++) begin
      for (int j = 0; j < 5; j++) begin
        set_idle();
        valid = 1'b1;
        branch = 1'b1;
        bcu_op = bcu_op_t'(k);
        pc = 32'h0000_0400;
        imm = 32'h0000_0040;
        rdata1 = lhs[j];
        rdata2 = rhs[j];
        wait_for_result(1);
        expect_equal(q_jump, branch_model(bcu_op_t'(k), lhs[j], rhs[j]), "branch taken");
        expect_equal(q_wren, 1'b0, "branch wren");
        expect_equal(q_address, 32'h0000_0440, "branch target");
      end
    end
  endtask

  task automatic test_mem();
    lsu_op_t op;
    logic is_load;
    logic bad;
    word_t base;
    word_t offset;
    word_t data;
    addr_t target;
    byte_en_t lanes;
    for (int k = 0; k < 8; k++) begin
      for (int off = 0; off < 4; off++) begin
        op = lsu_op_t'(k);
        is_load = (k < 5); // lb through lw.
        base = ($urandom & 32'hffff_fffc) | off;
        offset = $urandom_range(0, 255) << 2;
        data = $urandom;
        target = base + offset;
        if (op == lb || op == lbu || op == sb) begin
          lanes = byte_en_t'(4'b0001 << off);
          bad = 1'b0;
        end else if (op == lh || op == lhu || op == sh) begin
          lanes = byte_en_t'(4'b0011 << off);
          bad = off[0];
        end else begin
          lanes = 4'b1111;
          bad = (off != 0);
        end
        set_idle();
        valid = 1'b1;
        load = is_load;
        store = !is_load;
        lsu_op = op;
        rdata1 = base;
        rdata2 = data;
        imm = offset;
        wren = is_load;
        waddr = 5'd12;
        wait_for_result(1);
        expect_equal(q_address, target, "access address");
        expect_equal(q_sdata, data, "store data");
        expect_equal(q_lsu_op, op, "access op");
        expect_equal(q_exception, bad, "misaligned access");
        expect_equal(q_load, is_load & !bad, "load flag");
        expect_equal(q_store, !is_load & !bad, "store flag");
        expect_equal(q_wren, is_load & !bad, "load wren");
        if (bad) begin
          expect_equal(q_ecause, is_load ? cause_load_misaligned : cause_store_misaligned,
                       "misaligned cause");
          expect_equal(q_etval, target, "misaligned tval");
        end else begin
          expect_equal(q_byteenable, lanes, "byte enable");
        end
      end
    end
  endtask

  task automatic run_divide(input div_op_t op, input word_t a, input word_t b);
    set_idle();
    valid = 1'b1;
    division = 1'b1;
    div_op = op;
    rdata1 = a;
    rdata2 = b;
    wren = 1'b1;
    waddr = 5'd10;
    wait_for_result(34);
    expect_equal(stall_cycles + 1, 34, "divide latency");
    expect_equal(q_wdata, div_model(op, a, b), "divide result");
    expect_equal(q_wren, 1'b1, "divide wren");
  endtask

  task automatic test_muldiv();
    word_t a;
    word_t b;
    for (int i = 0; i < 40; i++) begin
      a = (i < 8) ? 32'h8000_0000 : $urandom;
      b = (i < 4) ? 32'h8000_0000 : ((i < 8) ? 32'hffff_ffff : $urandom);
      set_idle();
      valid = 1'b1;
      multiplication = 1'b1;
      mul_op = mul_op_t'(i % 4);
      rdata1 = a;
      rdata2 = b;
      wren = 1'b1;
      waddr = 5'd9;
      wait_for_result(1);
      expect_equal(q_wdata, mul_model(mul_op_t'(i % 4), a, b), "multiply result");
    end
    for (int i = 0; i < 24; i++) begin
      if (i < 4) begin
        a = 32'h1234_5678;
        b = '0; // divide by zero.
      end else if (i < 8) begin
        a = 32'h8000_0000;
        b = 32'hffff_ffff;
      end else if (i % 4 == 3) begin
        a = $urandom;
        b = -word_t'($urandom_range(1, 300));
      end else begin
        a = $urandom;
        b = (i % 2 == 0) ? word_t'($urandom_range(1, 300)) : word_t'($urandom);
      end
      run_divide(div_op_t'(i % 4), a, b);
    end
  endtask

  task automatic test_flush();
    logic [149:0] held;
    set_idle();
    valid = 1'b1;
    division = 1'b1;
    div_op = divu;
    rdata1 = 32'd1000;
    rdata2 = 32'd7;
    wren = 1'b1;
    waddr = 5'd4;
    #1;
    expect_equal(stall, 1'b1, "stall on divide");
    repeat (10) @(negedge clk);
    expect_equal(q_valid, 1'b0, "q_valid while dividing");
    clear = 1'b1; // divide still presented in the clear cycle.
    #1;
    expect_equal(stall, 1'b0, "stall during clear");
    @(negedge clk);
    set_idle();
    expect_equal(q_valid, 1'b0, "q_valid after clear");
    expect_equal(q_wren, 1'b0, "q_wren after clear");
    @(negedge clk);
    run_divide(divu, 32'd5000, 32'd9); // divider back from idle.

    // memory stage back-pressure.
    set_idle();
    valid = 1'b1;
    rden2 = 1'b1;
    rdata1 = 32'h0000_1111;
    rdata2 = 32'h0000_2222;
    alu_op = add;
    wren = 1'b1;
    waddr = 5'd3;
    wait_for_result(1);
    expect_equal(q_wdata, 32'h0000_3333, "add before hold");
    held = q_all;
    set_idle();
    valid = 1'b1;
    lui = 1'b1;
    imm = 32'h5555_5000;
    wren = 1'b1;
    waddr = 5'd6;
    mem_stall = 1'b1;
    repeat (5) begin
      @(negedge clk);
      expect_equal(q_all, held, "q held under mem_stall");
    end
    mem_stall = 1'b0;
    @(negedge clk);
    expect_equal(q_wdata, 32'h5555_5000, "lui after hold");
    expect_equal(q_waddr, 5'd6, "waddr after hold");

    // divide keeps running under mem_stall.
    set_idle();
    valid = 1'b1;
    division = 1'b1;
    div_op = rem;
    rdata1 = -32'd100;
    rdata2 = 32'd7;
    wren = 1'b1;
    waddr = 5'd7;
    repeat (5) @(negedge clk);
    mem_stall = 1'b1;
    repeat (4) @(negedge clk);
    mem_stall = 1'b0;
    wait_for_result(34);
    expect_equal(stall_cycles + 10, 34, "divide latency under mem_stall");
    expect_equal(q_wdata, div_model(rem, -32'd100, 32'd7), "remainder after hold");
  endtask

  // ============================================================
  // run
  // ============================================================
  initial begin
    int seed;
    seed = $urandom(32'hc2ebea17);
    rst = 1'b0;
    set_idle();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
    test_alu();
    test_jumps();
    test_branches();
    test_mem();
    test_muldiv();
    test_flush();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- test/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #10 clk = ~clk; // 20 ns period.

endmodule
